//--- tests/bridgeStim.txt
# op trans addr wdata expsel exprdata, all values hex
# op is W write, R read or I idle; expsel 0 means no APB transfer is expected
W 2 80000000 11110000 1 00000000
I 0 00000000 00000000 0 00000000
R 2 80000000 00000000 1 11110000
I 0 00000000 00000000 0 00000000
W 2 84000010 22220010 2 00000000
W 3 84000014 22220014 2 00000000
I 0 00000000 00000000 0 00000000
R 2 84000010 00000000 2 22220010
R 3 84000014 00000000 2 22220014
I 0 00000000 00000000 0 00000000
W 2 88000020 33330020 4 00000000
W 3 88000024 33330024 4 00000000
W 3 88000028 33330028 4 00000000
R 2 88000024 00000000 4 33330024
I 0 00000000 00000000 0 00000000
W 2 83FFFFFC 0A0A0A0A 1 00000000
R 2 83FFFFFC 00000000 1 0A0A0A0A
I 0 00000000 00000000 0 00000000
R 2 90000000 00000000 0 00000000
W 2 7FFFFFFC DEADBEEF 0 00000000
W 2 8C000000 DEADBEEF 0 00000000
I 1 80000000 00000000 0 00000000
W 1 84000000 DEADBEEF 0 00000000
R 2 80000000 00000000 1 11110000
W 2 87FFFFFC 44444444 2 00000000
R 2 87FFFFFC 00000000 2 44444444
R 2 84000010 00000000 2 22220010
W 2 80000004 55555555 1 00000000
W 3 84000020 66666666 2 00000000
R 2 80000004 00000000 1 55555555
W 2 88000000 77777777 4 00000000
R 2 A0000000 00000000 0 00000000
W 2 88000004 88888888 4 00000000
I 0 00000000 00000000 0 00000000
W 2 80000000 99999999 1 00000000
R 2 80000000 00000000 1 99999999
W 3 88000020 ABABABAB 4 00000000
R 3 88000020 00000000 4 ABABABAB
I 0 00000000 00000000 0 00000000
R 2 84000020 00000000 2 66666666
W 2 8800003C 12345678 4 00000000
W 3 80000008 87654321 1 00000000
R 3 8800003C 00000000 4 12345678
R 3 80000008 00000000 1 87654321
I 1 88000000 00000000 0 00000000
R 2 88000000 00000000 4 77777777
R 2 88000004 00000000 4 88888888
W 2 8BFFFFFC CAFEF00D 4 00000000
R 2 8BFFFFFC 00000000 4 CAFEF00D
I 0 00000000 00000000 0 00000000

//--- flist.f
rtl/bridgePkg.sv
rtl/ahbSlaveInterface.sv
rtl/transferPipe.sv
rtl/apbFsmController.sv
rtl/ahbApbBridge.sv
tests/bridgeTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module bridgeTb -f flist.f -o bridgeSim

output=$(./obj_dir/bridgeSim 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi

//--- tests/bridgeTb.sv
`timescale 1ns/1ps

module bridgeTb;

	localparam int maxLines = 128;

	logic             Hclk;
	logic             Hresetn;
	bridgePkg::addr_t Haddr;
	logic [1:0]       Htrans;
	logic             Hwrite;
	bridgePkg::data_t Hwdata;
	logic             Hreadyin;
	logic             Hreadyout;
	bridgePkg::data_t Hrdata;
	logic [1:0]       Hresp;
	bridgePkg::sel_t  Pselx;
	logic             Penable;
	logic             Pwrite;
	bridgePkg::addr_t Paddr;
	bridgePkg::data_t Pwdata;
	bridgePkg::data_t Prdata;

	// one line of the stimulus file per entry
	logic [7:0]  lineOp    [maxLines];
	logic [1:0]  lineTrans [maxLines];
	logic [31:0] lineAddr  [maxLines];
	logic [31:0] lineWdata [maxLines];
	int          lineCount;

	// valid transfers in the order the APB side should show them
	logic [2:0]  expSel   [maxLines];
	logic [31:0] expAddr  [maxLines];
	logic        expWrite [maxLines];
	logic [31:0] expWdata [maxLines];
	logic [31:0] expRdata [maxLines];
	int          expCount;
	int          seenCount;

	// peripheral memories are keyed by the full APB address
	logic [31:0] periphMem [logic [31:0]];

	logic [15:0] lfsrState;
	int          cycleCount;
	int          cycleLimit;
	bit          pendingData;
	logic [31:0] pendingWdata;
	bit          inSetup;
	logic [2:0]  setupSel;
	logic [31:0] setupAddr;
	logic        setupWrite;

	// single AHB slave, so the bus ready is the bridge's own ready
	assign Hreadyin = Hreadyout;

	ahbApbBridge ahbApbBridge_inst
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Haddr     (Haddr),
		.Htrans    (Htrans),
		.Hwrite    (Hwrite),
		.Hwdata    (Hwdata),
		.Hreadyin  (Hreadyin),
		.Hreadyout (Hreadyout),
		.Hrdata    (Hrdata),
		.Hresp     (Hresp),
		.Pselx     (Pselx),
		.Penable   (Penable),
		.Pwrite    (Pwrite),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata),
		.Prdata    (Prdata)
	);

	initial
	begin
		Hclk = 1'b0;
		forever #2 Hclk = ~Hclk;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			failRun($sformatf("** Error %s expected 0x%h actual 0x%h", name, expected, actual));
		end
	endtask

	// taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit handed out
	function automatic logic nextRandomBit();
		logic feedback;
		feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], feedback};
		return feedback;
	endfunction

	// hold an address phase until the bridge accepts it
	// the write beat of the previous accepted write goes out alongside it
	task automatic issuePhase(input logic [31:0] addr, input logic [1:0] trans,
		input logic write, input logic [31:0] wdata, input bit carriesData);
		@(posedge Hclk);
		#1;
		Haddr  = addr;
		Htrans = trans;
		Hwrite = write;
		if (pendingData)
		begin
			Hwdata      = pendingWdata;
			pendingData = 1'b0;
		end
		while (!Hreadyout)
		begin
			@(posedge Hclk);
			#1;
		end
		if (carriesData)
		begin
			pendingData  = 1'b1;
			pendingWdata = wdata;
		end
	endtask

	task automatic readStimulus();
		int    fd;
		int    fields;
		string lineText;
		logic [2:0]  sel;
		logic [31:0] rdata;
		fd = $fopen("tests/bridgeStim.txt", "r");
		if (fd == 0)
		begin
			failRun("could not open the stimulus file tests/bridgeStim.txt");
		end
		lineCount = 0;
		expCount  = 0;
		while (!$feof(fd))
		begin
			lineText = "";
			void'($fgets(lineText, fd));
			if (lineText.len() < 2 || lineText[0] == "#")
			begin
				continue;
			end
			fields = $sscanf(lineText, "%c %h %h %h %h %h", lineOp[lineCount],
				lineTrans[lineCount], lineAddr[lineCount], lineWdata[lineCount], sel, rdata);
			if (fields != 6)
			begin
				failRun($sformatf("malformed stimulus line: %s", lineText));
			end
			// a nonzero expected select marks a transfer the APB side must show
			if (lineOp[lineCount] != "I" && lineTrans[lineCount][1] && sel != 3'b000)
			begin
				expSel[expCount]   = sel;
				expAddr[expCount]  = lineAddr[lineCount];
				expWrite[expCount] = (lineOp[lineCount] == "W");
				expWdata[expCount] = lineWdata[lineCount];
				expRdata[expCount] = rdata;
				expCount++;
			end
			lineCount++;
		end
		$fclose(fd);
	endtask

	// a stuck bridge ends the run here
	always @(posedge Hclk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			failRun($sformatf("the run timed out after %0d cycles", cycleCount));
		end
	end

	// peripheral read data is presented in the enable cycle
	always @(posedge Hclk)
	begin
		#1;
		if (Penable && !Pwrite && Pselx != 3'b000 && periphMem.exists(Paddr))
		begin
			Prdata <= periphMem[Paddr];
		end
		else
		begin
			Prdata <= '0;
		end
	end

	// the APB monitor samples mid-cycle where the registered outputs are settled
	always @(negedge Hclk)
	begin
		if (Hresetn)
		begin
			if (Pselx != 3'b000 && !Penable)
			begin
				if (inSetup)
				begin
					failRun("an APB setup cycle lasted more than one cycle");
				end
				inSetup    = 1'b1;
				setupSel   = Pselx;
				setupAddr  = Paddr;
				setupWrite = Pwrite;
			end
			else if (Penable)
			begin
				if (!inSetup)
				begin
					failRun("an APB enable cycle came without a setup cycle before it");
				end
				inSetup = 1'b0;
				checkValue("Pselx", 32'(setupSel), 32'(Pselx));
				checkValue("Paddr", setupAddr, Paddr);
				checkValue("Pwrite", 32'(setupWrite), 32'(Pwrite));
				if (seenCount >= expCount)
				begin
					failRun("an APB transfer appeared with no matching AHB transfer");
				end
				checkValue("Pselx", 32'(expSel[seenCount]), 32'(Pselx));
				checkValue("Paddr", expAddr[seenCount], Paddr);
				checkValue("Pwrite", 32'(expWrite[seenCount]), 32'(Pwrite));
				checkValue("Hresp", 32'h0, 32'(Hresp));
				if (Pwrite)
				begin
					checkValue("Pwdata", expWdata[seenCount], Pwdata);
					periphMem[Paddr] = Pwdata;
				end
				else
				begin
					checkValue("Hrdata", expRdata[seenCount], Hrdata);
				end
				seenCount++;
			end
			else if (inSetup)
			begin
				failRun("an APB setup cycle was not followed by an enable cycle");
			end
		end
	end

	initial
	begin
		logic [1:0] gapBits;
		Hresetn      = 1'b0;
		Haddr        = '0;
		Htrans       = 2'b00;
		Hwrite       = 1'b0;
		Hwdata       = '0;
		Prdata       = '0;
		lfsrState    = 16'd53227;
		cycleCount   = 0;
		cycleLimit   = 1000000;
		pendingData  = 1'b0;
		pendingWdata = '0;
		inSetup      = 1'b0;
		seenCount    = 0;
		readStimulus();
		cycleLimit = 10 * lineCount + 100;

		repeat (4) @(posedge Hclk);
		#1;
		checkValue("Pselx", 32'h0, 32'(Pselx));
		checkValue("Penable", 32'h0, 32'(Penable));
		checkValue("Pwrite", 32'h0, 32'(Pwrite));
		checkValue("Paddr", 32'h0, Paddr);
		checkValue("Pwdata", 32'h0, Pwdata);
		Hresetn = 1'b1;
		// ready stays low until the first edge out of reset
		checkValue("Hreadyout", 32'h0, 32'(Hreadyout));
		@(posedge Hclk);
		#1;
		checkValue("Hreadyout", 32'h1, 32'(Hreadyout));

		for (int i = 0; i < lineCount; i++)
		begin
			issuePhase(lineAddr[i], lineTrans[i], lineOp[i] == "W", lineWdata[i],
				lineOp[i] == "W" && lineTrans[i][1]);
			// random idle only after idle lines, so back-to-back lines stay adjacent
			if (lineOp[i] == "I")
			begin
				gapBits[1] = nextRandomBit();
				gapBits[0] = nextRandomBit();
				repeat (gapBits) issuePhase('0, 2'b00, 1'b0, '0, 1'b0);
			end
		end
		issuePhase('0, 2'b00, 1'b0, '0, 1'b0);

		while (seenCount < expCount)
		begin
			@(posedge Hclk);
		end
		// the monitor flags any stray transfer that follows the last one
		repeat (10) @(posedge Hclk);
		#1;
		checkValue("Hreadyout", 32'h1, 32'(Hreadyout));

		$display("test passed");
		$finish;
	end

endmodule

//--- rtl/ahbApbBridge.sv
`timescale 1ns/1ps

module ahbApbBridge
(
	input  logic             Hclk,
	input  logic             Hresetn,
	input  bridgePkg::addr_t Haddr,
	input  logic [1:0]       Htrans,
	input  logic             Hwrite,
	input  bridgePkg::data_t Hwdata,
	input  logic             Hreadyin,
	output logic             Hreadyout,
	output bridgePkg::data_t Hrdata,
	output logic [1:0]       Hresp,
	output bridgePkg::sel_t  Pselx,
	output logic             Penable,
	output logic             Pwrite,
	output bridgePkg::addr_t Paddr,
	output bridgePkg::data_t Pwdata,
	input  bridgePkg::data_t Prdata
);

	logic                  valid;
	bridgePkg::sel_t       tempSelx;
	bridgePkg::ahbPhase_t  phase;
	bridgePkg::pipeState_t pipe;
	bridgePkg::apbReq_t    req;

	// decode and address phase capture
	ahbSlaveInterface ahbSlaveInterface_inst
	(
		.Hclk     (Hclk),
		.Hresetn  (Hresetn),
		.Haddr    (Haddr),
		.Htrans   (bridgePkg::htrans_t'(Htrans)),
		.Hwrite   (Hwrite),
		.Hreadyin (Hreadyin),
		.valid    (valid),
		.tempSelx (tempSelx),
		.phase    (phase)
	);

	// address and write data history for back-to-back writes
	transferPipe transferPipe_inst
	(
		.Hclk     (Hclk),
		.Hresetn  (Hresetn),
		.phase    (phase),
		.Hwdata   (Hwdata),
		.Hreadyin (Hreadyin),
		.pipe     (pipe)
	);

	// APB sequencing and the AHB stall
	apbFsmController apbFsmController_inst
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.valid     (valid),
		.Hwrite    (Hwrite),
		.Haddr     (Haddr),
		.Hwdata    (Hwdata),
		.tempSelx  (tempSelx),
		.pipe      (pipe),
		.phase     (phase),
		.req       (req),
		.Hreadyout (Hreadyout)
	);

	// APB pins straight from the registered request
	assign Pselx   = req.sel;
	assign Penable = req.enable;
	assign Pwrite  = req.write;
	assign Paddr   = req.addr;
	assign Pwdata  = req.wdata;

	// read data is valid in the enable cycle, which is when Hreadyout rises
	assign Hrdata = Prdata;

	// the bridge never signals an error so Hresp stays OKAY
	assign Hresp = 2'b00;

endmodule

//--- rtl/apbFsmController.sv
`timescale 1ns/1ps

module apbFsmController
(
	input  logic                  Hclk,
	input  logic                  Hresetn,
	input  logic                  valid,
	input  logic                  Hwrite,
	input  bridgePkg::addr_t      Haddr,
	input  bridgePkg::data_t      Hwdata,
	input  bridgePkg::sel_t       tempSelx,
	input  bridgePkg::pipeState_t pipe,
	input  bridgePkg::ahbPhase_t  phase,
	output bridgePkg::apbReq_t    req,
	output logic                  Hreadyout
);

	bridgePkg::apbState_t presentState;
	bridgePkg::apbState_t nextState;

	// values the output registers take on the next edge
	bridgePkg::apbReq_t nextReq;
	logic               nextReady;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			presentState <= bridgePkg::stIdle;
		end
		else
		begin
			presentState <= nextState;
		end
	end

	// transition rules on valid, Hwrite and the registered write flag
	always_comb
	begin
		nextState = bridgePkg::stIdle;
		case (presentState)
			// the bus is free in these three, so they all dispatch the same way
			bridgePkg::stIdle,
			bridgePkg::stREnable,
			bridgePkg::stWEnable:
			begin
				if (!valid)
				begin
					nextState = bridgePkg::stIdle;
				end
				else if (Hwrite)
				begin
					nextState = bridgePkg::stWwait;
				end
				else
				begin
					nextState = bridgePkg::stRead;
				end
			end
			// a transfer arriving during the wait is parked behind this write
			bridgePkg::stWwait:
			begin
				if (!valid)
				begin
					nextState = bridgePkg::stWrite;
				end
				else
				begin
					nextState = bridgePkg::stWriteP;
				end
			end
			bridgePkg::stRead:
			begin
				nextState = bridgePkg::stREnable;
			end
			bridgePkg::stWrite:
			begin
				if (!valid)
				begin
					nextState = bridgePkg::stWEnable;
				end
				else
				begin
					nextState = bridgePkg::stWEnableP;
				end
			end
			bridgePkg::stWriteP:
			begin
				nextState = bridgePkg::stWEnableP;
			end
			// writeReg says whether the parked transfer is a write or a read
			bridgePkg::stWEnableP:
			begin
				if (!valid && pipe.writeReg)
				begin
					nextState = bridgePkg::stWrite;
				end
				else if (valid && pipe.writeReg)
				begin
					nextState = bridgePkg::stWriteP;
				end
				else
				begin
					nextState = bridgePkg::stRead;
				end
			end
			default:
			begin
				nextState = bridgePkg::stIdle;
			end
		endcase
	end

	// next-output logic
	// anything a state leaves alone keeps its registered value, which keeps
	// Pselx, Paddr, Pwrite and Pwdata steady from setup through enable
	always_comb
	begin
		nextReq   = req;
		nextReady = Hreadyout;
		case (presentState)
			bridgePkg::stIdle,
			bridgePkg::stREnable,
			bridgePkg::stWEnable:
			begin
				if (valid && !Hwrite)
				begin
					// a read goes straight to setup from the live address phase
					// and Hreadyout drops so its data phase waits for Prdata
					nextReq.addr   = Haddr;
					nextReq.write  = 1'b0;
					nextReq.sel    = tempSelx;
					nextReq.enable = 1'b0;
					nextReady      = 1'b0;
				end
				else
				begin
					// idle or a write that first needs its data beat
					// the write data phase completes at once and the beat is taken in WWAIT
					nextReq.sel    = '0;
					nextReq.enable = 1'b0;
					nextReady      = 1'b1;
				end
			end
			bridgePkg::stWwait:
			begin
				// data beat is on Hwdata now
				// address and select come from the captured phase, since the live
				// decode may already show the next transfer
				nextReq.addr   = phase.addr;
				nextReq.write  = 1'b1;
				nextReq.sel    = phase.sel;
				nextReq.wdata  = Hwdata;
				nextReq.enable = 1'b0;
				nextReady      = 1'b0;
			end
			bridgePkg::stRead,
			bridgePkg::stWrite:
			begin
				// enable cycle follows, so the AHB data phase may finish with it
				nextReq.enable = 1'b1;
				nextReady      = 1'b1;
			end
			bridgePkg::stWriteP:
			begin
				// phase now holds the parked transfer
				// a parked write may finish its data phase during the enable cycle
				// while a parked read must keep waiting for its own APB access
				nextReq.enable = 1'b1;
				nextReady      = phase.write;
			end
			bridgePkg::stWEnableP:
			begin
				// set up the parked transfer from the second pipe stage
				nextReq.addr   = pipe.addr2;
				nextReq.write  = pipe.writeReg;
				nextReq.sel    = phase.sel;
				nextReq.wdata  = pipe.wdata2;
				nextReq.enable = 1'b0;
				nextReady      = 1'b0;
			end
			default:
			begin
				nextReq.sel    = '0;
				nextReq.enable = 1'b0;
				nextReady      = 1'b1;
			end
		endcase
	end

	// registered outputs go low or zero out of reset
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			req       <= '0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			req       <= nextReq;
			Hreadyout <= nextReady;
		end
	end

endmodule

//--- rtl/transferPipe.sv
`timescale 1ns/1ps

module transferPipe
(
	input  logic                  Hclk,
	input  logic                  Hresetn,
	input  bridgePkg::ahbPhase_t  phase,
	input  bridgePkg::data_t      Hwdata,
	input  logic                  Hreadyin,
	output bridgePkg::pipeState_t pipe
);

	bridgePkg::addr_t addrStage1;
	bridgePkg::addr_t addrStage2;
	bridgePkg::data_t beatStage1;
	bridgePkg::data_t beatStage2;
	logic             writeFlag;

	// first stage is one cycle of history behind the phase register and the
	// write data bus, so the beat lands here a cycle after its address phase
	// second stage follows the first while the bus is moving
	// when the bridge holds Hreadyout low the master parks the next transfer
	// on the bus, and the second stage captures that parked address and beat
	// directly so WENABLEP can set it up without waiting for the first stage
	always_ff @(posedge Hclk)
	begin
		addrStage1 <= phase.addr;
		beatStage1 <= Hwdata;
		if (Hreadyin)
		begin
			addrStage2 <= addrStage1;
			beatStage2 <= beatStage1;
		end
		else
		begin
			addrStage2 <= phase.addr;
			beatStage2 <= Hwdata;
		end
	end

	// direction of the parked transfer
	// in WENABLEP this picks WRITE/WRITEP against READ
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			writeFlag <= 1'b0;
		end
		else
		begin
			writeFlag <= phase.write;
		end
	end

	assign pipe = '{
		addr1:    addrStage1,
		addr2:    addrStage2,
		wdata1:   beatStage1,
		wdata2:   beatStage2,
		writeReg: writeFlag
	};

endmodule

//--- rtl/ahbSlaveInterface.sv
`timescale 1ns/1ps

module ahbSlaveInterface
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  bridgePkg::addr_t     Haddr,
	input  bridgePkg::htrans_t   Htrans,
	input  logic                 Hwrite,
	input  logic                 Hreadyin,
	output logic                 valid,
	output bridgePkg::sel_t      tempSelx,
	output bridgePkg::ahbPhase_t phase
);

	// the transfer type asks for a bus access
	logic transActive;
	// the address falls inside one of the three windows
	logic inRegion;

	// region decode straight off the address bus in the same cycle
	// each window is compared on both ends so the map stays explicit
	always_comb
	begin
		tempSelx = '0;
		if ((Haddr >= bridgePkg::periph0Base) && (Haddr < bridgePkg::periph1Base))
		begin
			tempSelx = 3'b001;
		end
		else if ((Haddr >= bridgePkg::periph1Base) && (Haddr < bridgePkg::periph2Base))
		begin
			tempSelx = 3'b010;
		end
		else if ((Haddr >= bridgePkg::periph2Base) && (Haddr < bridgePkg::regionTop))
		begin
			tempSelx = 3'b100;
		end
	end

	// IDLE and BUSY carry no access and only NONSEQ and SEQ do
	assign transActive = (Htrans == bridgePkg::htransNonseq) ||
		(Htrans == bridgePkg::htransSeq);

	// an address outside every window decodes to an all-zero select
	assign inRegion = |tempSelx;

	// a transfer counts only when the previous data phase is finishing,
	// otherwise the master is still holding its address phase
	assign valid = Hreadyin && transActive && inRegion;

	// capture the address phase whenever the bus moves on
	// while Hreadyin is low the master holds its phase and so do we
	// the write stage and the enable-stage setup read sel from here because the
	// live decode already belongs to the next transfer by then
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			phase <= '0;
		end
		else if (Hreadyin)
		begin
			phase.addr  <= Haddr;
			phase.write <= Hwrite;
			phase.sel   <= tempSelx;
		end
	end

endmodule

//--- rtl/bridgePkg.sv
package bridgePkg;

	// byte address as seen on both buses
	typedef logic [31:0] addr_t;

	// one data word with the same width for Hwdata, Hrdata, Pwdata and Prdata
	typedef logic [31:0] data_t;

	// one-hot peripheral select where bit n picks peripheral n
	typedef logic [2:0] sel_t;

	// AHB Htrans encoding
	typedef enum logic [1:0]
	{
		htransIdle   = 2'b00,
		htransBusy   = 2'b01,
		htransNonseq = 2'b10,
		htransSeq    = 2'b11
	} htrans_t;

	// three 64 MB windows laid out back to back from 0x8000_0000
	localparam addr_t periph0Base = 32'h8000_0000;
	localparam addr_t periph1Base = 32'h8400_0000;
	localparam addr_t periph2Base = 32'h8800_0000;
	// first address above peripheral 2
	localparam addr_t regionTop   = 32'h8C00_0000;

	// APB controller states
	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100,
		stREnable  = 3'b101,
		stWEnable  = 3'b110,
		stWEnableP = 3'b111
	} apbState_t;

	// address phase captured on an edge with Hreadyin high
	typedef struct packed
	{
		addr_t addr;
		logic  write;
		sel_t  sel;
	} ahbPhase_t;

	// stage 1 is plain history and stage 2 holds the transfer parked behind a stall
	typedef struct packed
	{
		addr_t addr1;
		addr_t addr2;
		data_t wdata1;
		data_t wdata2;
		logic  writeReg;
	} pipeState_t;

	// registered APB request that the top level splits onto the pins
	typedef struct packed
	{
		sel_t  sel;
		logic  enable;
		logic  write;
		addr_t addr;
		data_t wdata;
	} apbReq_t;

endpackage
